/* common/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ==================================================
// Instruction word layout
// ==================================================

`define WORD_WIDTH   32  // Full IR width
`define OPCODE_MSB   31  // Opcode sits at the top of IR
`define OPCODE_WIDTH 5   // IR[31:27]

// ==================================================
// Control path widths
// ==================================================

`define ALU_OP_WIDTH 5   // ALU select code
`define STEP_WIDTH   3   // Up to 8 execute steps

// Longest instruction (load/store) needs steps 0..4
// so 3 bits leave some room for growth

`endif

/* common/isaPkg.sv */
`include "cpu_settings.svh"

package isaPkg;

    // ==================================================
    // Opcode encoding
    // ==================================================
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        opLoad    = 5'd0,   // ld
        opLoadImm = 5'd1,   // ldi
        opStore   = 5'd2,   // st
        opAdd     = 5'd3,
        opSub     = 5'd4,
        opShr     = 5'd5,
        opShra    = 5'd6,   // Arithmetic shift right
        opShl     = 5'd7,
        opRor     = 5'd8,
        opRol     = 5'd9,
        opAnd     = 5'd10,
        opOr      = 5'd11,
        opAddi    = 5'd12,  // Immediate group
        opAndi    = 5'd13,
        opOri     = 5'd14,
        opBranch  = 5'd19,  // Conditional branch
        opNop     = 5'd26,
        opHalt    = 5'd27
    } opcodeT;

    // ==================================================
    // ALU select codes
    // ==================================================
    // Same numbers as the register opcodes
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        aluNone = 5'd0,     // ALU idle
        aluAdd  = 5'd3,
        aluSub  = 5'd4,
        aluShr  = 5'd5,
        aluShra = 5'd6,
        aluShl  = 5'd7,
        aluRor  = 5'd8,
        aluRol  = 5'd9,
        aluAnd  = 5'd10,
        aluOr   = 5'd11
    } aluOpT;

    // ==================================================
    // Instruction classes
    // ==================================================
    // One class per distinct execute pattern
    typedef enum logic [2:0] {
        classLoad,          // 5 steps with a memory read
        classLoadImm,       // 3 steps
        classStore,         // 5 steps with a memory write
        classAluReg,        // 3 steps with an Rc operand
        classAluImm,        // 3 steps with a constant operand
        classBranch,        // 4 steps
        classNop,           // No execute steps
        classHalt           // Stops the machine
    } instrClassT;

endpackage

/* common/sequencePkg.sv */
`include "cpu_settings.svh"

package sequencePkg;

    // ==================================================
    // Sequencer phases
    // ==================================================
    typedef enum logic [2:0] {
        phaseIdle,      // After reset, no strobes
        phaseFetch0,    // PC to MAR, PC+1 to Z
        phaseFetch1,    // Z to PC, memory to MDR
        phaseFetch2,    // MDR to IR
        phaseDecode,    // IR settled, pick class
        phaseExecute,   // Per-class steps
        phaseHalted     // Parked until reset
    } phaseT;

    // Execute step index, 0 is the first step
    typedef logic [`STEP_WIDTH-1:0] stepT;

endpackage

/* decode/instrDecoder.sv */
`include "cpu_settings.svh"

module instrDecoder
    import isaPkg::*;
(
    input  logic [`WORD_WIDTH-1:0] ir,
    output instrClassT             instrClass,
    output aluOpT                  decodedAluOp
);

    logic [`OPCODE_WIDTH-1:0] opField;  // IR[31:27]

    assign opField = ir[`OPCODE_MSB -: `OPCODE_WIDTH];

    // ==================================================
    // Opcode to class
    // ==================================================
    always_comb begin
        case (opField)
            opLoad:    instrClass = classLoad;
            opLoadImm: instrClass = classLoadImm;
            opStore:   instrClass = classStore;
            opAdd, opSub, opShr, opShra, opShl,
            opRor, opRol, opAnd, opOr: begin
                instrClass = classAluReg;       // Two register sources
            end
            opAddi, opAndi, opOri: begin
                instrClass = classAluImm;       // Register plus constant
            end
            opBranch:  instrClass = classBranch;
            opHalt:    instrClass = classHalt;
            default:   instrClass = classNop;   // Unused opcodes do nothing
        endcase
    end

    // ==================================================
    // Opcode to ALU operation
    // ==================================================
    always_comb begin
        case (opField)
            opAdd:   decodedAluOp = aluAdd;
            opSub:   decodedAluOp = aluSub;
            opShr:   decodedAluOp = aluShr;
            opShra:  decodedAluOp = aluShra;
            opShl:   decodedAluOp = aluShl;
            opRor:   decodedAluOp = aluRor;
            opRol:   decodedAluOp = aluRol;
            opAnd:   decodedAluOp = aluAnd;
            opOr:    decodedAluOp = aluOr;
            // Immediate forms reuse the register operation
            opAddi:  decodedAluOp = aluAdd;
            opAndi:  decodedAluOp = aluAnd;
            opOri:   decodedAluOp = aluOr;
            default: decodedAluOp = aluNone;    // Load/store/branch add is fixed downstream
        endcase
    end

endmodule

/* sequencer/stepSequencer.sv */
module stepSequencer
    import isaPkg::*;
    import sequencePkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       stop,        // Level sampled at every edge
    input  instrClassT instrClass,
    output phaseT      phase,
    output stepT       step
);

    stepT lastStep;     // Final step index of current class
    logic atLastStep;

    // ==================================================
    // Execute length per class
    // ==================================================
    always_comb begin
        case (instrClass)
            classLoad, classStore:   lastStep = stepT'(4);   // 5 steps
            classBranch:             lastStep = stepT'(3);   // 4 steps
            classLoadImm,
            classAluReg, classAluImm: lastStep = stepT'(2);  // 3 steps
            default:                 lastStep = stepT'(0);   // Nop/halt never execute
        endcase
    end

    assign atLastStep = (step == lastStep);

    // ==================================================
    // Phase and step registers
    // ==================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            phase <= phaseIdle;
            step  <= '0;
        end else if (stop) begin
            phase <= phaseHalted;   // Stop wins over everything
            step  <= '0;
        end else begin
            case (phase)
                phaseIdle:   phase <= phaseFetch0;
                phaseFetch0: phase <= phaseFetch1;
                phaseFetch1: phase <= phaseFetch2;
                phaseFetch2: phase <= phaseDecode;   // IR loads at this edge
                phaseDecode: begin
                    step <= '0;
                    case (instrClass)
                        classNop:  phase <= phaseFetch0;  // Straight to next fetch
                        classHalt: phase <= phaseHalted;
                        default:   phase <= phaseExecute;
                    endcase
                end
                phaseExecute: begin
                    if (atLastStep) begin
                        phase <= phaseFetch0;   // Instruction done
                        step  <= '0;
                    end else begin
                        step <= step + stepT'(1);
                    end
                end
                phaseHalted: begin
                    phase <= phaseHalted;       // Only reset leaves
                    step  <= '0;
                end
                default: begin
                    phase <= phaseIdle;         // Unused encoding
                    step  <= '0;
                end
            endcase
        end
    end

endmodule

/* signals/controlSignalGen.sv */
module controlSignalGen
    import isaPkg::*;
    import sequencePkg::*;
(
    input  phaseT      phase,
    input  stepT       step,
    input  instrClassT instrClass,
    input  aluOpT      decodedAluOp,
    input  logic       conFlag,     // Branch condition FF
    output logic       gra,
    output logic       grb,
    output logic       grc,
    output logic       rIn,
    output logic       rOut,
    output logic       baOut,
    output logic       pcOut,
    output logic       incPc,
    output logic       pcIn,
    output logic       irIn,
    output logic       yIn,
    output logic       cOut,
    output logic       zLowOut,
    output logic       zIn,
    output logic       mdrOut,
    output logic       mdrIn,
    output logic       marIn,
    output logic       memRead,
    output logic       memWrite,
    output logic       conIn,
    output logic       run,
    output aluOpT      aluOp
);

    // Machine counts as running from first fetch until halt
    assign run = (phase != phaseIdle) && (phase != phaseHalted);

    always_comb begin
        gra      = 1'b0;
        grb      = 1'b0;
        grc      = 1'b0;
        rIn      = 1'b0;
        rOut     = 1'b0;
        baOut    = 1'b0;
        pcOut    = 1'b0;
        incPc    = 1'b0;
        pcIn     = 1'b0;
        irIn     = 1'b0;
        yIn      = 1'b0;
        cOut     = 1'b0;
        zLowOut  = 1'b0;
        zIn      = 1'b0;
        mdrOut   = 1'b0;
        mdrIn    = 1'b0;
        marIn    = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        conIn    = 1'b0;
        aluOp    = aluNone;

        case (phase)
            // ==================================================
            // Fetch, same for every instruction
            // ==================================================
            phaseFetch0: begin
                pcOut = 1'b1;   // PC onto bus
                marIn = 1'b1;
                incPc = 1'b1;   // Z gets PC+1
                zIn   = 1'b1;
            end
            phaseFetch1: begin
                zLowOut = 1'b1; // PC+1 back into PC
                pcIn    = 1'b1;
                memRead = 1'b1;
                mdrIn   = 1'b1;
            end
            phaseFetch2: begin
                mdrOut = 1'b1;  // Instruction word into IR
                irIn   = 1'b1;
            end

            // ==================================================
            // Execute steps per class
            // ==================================================
            phaseExecute: begin
                case (instrClass)
                    classLoad, classLoadImm, classStore: begin
                        if (step == stepT'(0)) begin
                            grb   = 1'b1;   // Base register, R0 reads as zero
                            baOut = 1'b1;
                            rOut  = 1'b1;
                            yIn   = 1'b1;
                        end else if (step == stepT'(1)) begin
                            cOut  = 1'b1;   // Offset plus base
                            zIn   = 1'b1;
                            aluOp = aluAdd;
                        end else if (step == stepT'(2)) begin
                            zLowOut = 1'b1;
                            if (instrClass == classLoadImm) begin
                                gra = 1'b1; // Sum is the result
                                rIn = 1'b1;
                            end else begin
                                marIn = 1'b1; // Sum is the address
                            end
                        end else if (step == stepT'(3)) begin
                            mdrIn = 1'b1;
                            if (instrClass == classLoad) begin
                                memRead = 1'b1;
                            end else if (instrClass == classStore) begin
                                gra  = 1'b1;    // Ra is store data
                                rOut = 1'b1;
                            end
                        end else if (step == stepT'(4)) begin
                            if (instrClass == classLoad) begin
                                mdrOut = 1'b1;
                                gra    = 1'b1;
                                rIn    = 1'b1;
                            end else if (instrClass == classStore) begin
                                memWrite = 1'b1;
                            end
                        end
                    end
                    classAluReg, classAluImm: begin
                        if (step == stepT'(0)) begin
                            grb  = 1'b1;    // Rb into Y
                            rOut = 1'b1;
                            yIn  = 1'b1;
                        end else if (step == stepT'(1)) begin
                            zIn   = 1'b1;
                            aluOp = decodedAluOp;
                            if (instrClass == classAluImm) begin
                                cOut = 1'b1;    // Constant operand
                            end else begin
                                grc  = 1'b1;    // Rc operand
                                rOut = 1'b1;
                            end
                        end else if (step == stepT'(2)) begin
                            zLowOut = 1'b1; // Result into Ra
                            gra     = 1'b1;
                            rIn     = 1'b1;
                        end
                    end
                    classBranch: begin
                        if (step == stepT'(0)) begin
                            gra   = 1'b1;   // Ra tested by CON logic
                            rOut  = 1'b1;
                            conIn = 1'b1;
                        end else if (step == stepT'(1)) begin
                            pcOut = 1'b1;
                            yIn   = 1'b1;
                        end else if (step == stepT'(2)) begin
                            cOut  = 1'b1;   // PC plus displacement
                            zIn   = 1'b1;
                            aluOp = aluAdd;
                        end else if (step == stepT'(3)) begin
                            zLowOut = 1'b1;
                            pcIn    = conFlag;  // Taken only if condition held
                        end
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

/* hw/controlUnit.sv */
module controlUnit
    import isaPkg::*;
    import sequencePkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] ir,         // IR contents from datapath
    input  logic        stop,
    input  logic        conFlag,
    output logic        gra,
    output logic        grb,
    output logic        grc,
    output logic        rIn,
    output logic        rOut,
    output logic        baOut,
    output logic        pcOut,
    output logic        incPc,
    output logic        pcIn,
    output logic        irIn,
    output logic        yIn,
    output logic        cOut,
    output logic        zLowOut,
    output logic        zIn,
    output logic        mdrOut,
    output logic        mdrIn,
    output logic        marIn,
    output logic        memRead,
    output logic        memWrite,
    output logic        conIn,
    output logic        run,
    output aluOpT       aluOp
);

    instrClassT instrClass;     // From decoder
    aluOpT      decodedAluOp;
    phaseT      phase;          // From sequencer
    stepT       step;

    // ==================================================
    // Decode, sequence, strobe generation
    // ==================================================
    instrDecoder decoder (
        .ir           (ir),
        .instrClass   (instrClass),
        .decodedAluOp (decodedAluOp)
    );

    stepSequencer sequencer (
        .clock      (clock),
        .reset      (reset),
        .stop       (stop),
        .instrClass (instrClass),
        .phase      (phase),
        .step       (step)
    );

    controlSignalGen signalGen (
        .phase        (phase),
        .step         (step),
        .instrClass   (instrClass),
        .decodedAluOp (decodedAluOp),
        .conFlag      (conFlag),
        .gra          (gra),
        .grb          (grb),
        .grc          (grc),
        .rIn          (rIn),
        .rOut         (rOut),
        .baOut        (baOut),
        .pcOut        (pcOut),
        .incPc        (incPc),
        .pcIn         (pcIn),
        .irIn         (irIn),
        .yIn          (yIn),
        .cOut         (cOut),
        .zLowOut      (zLowOut),
        .zIn          (zIn),
        .mdrOut       (mdrOut),
        .mdrIn        (mdrIn),
        .marIn        (marIn),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .conIn        (conIn),
        .run          (run),
        .aluOp        (aluOp)
    );

endmodule

/* tests/controlUnitTb.sv */
module controlUnitTb
    import isaPkg::*;
    import sequencePkg::*;
();

    // ==================================================
    // DUT signals
    // ==================================================
    logic        clock;
    logic        reset;
    logic [31:0] ir;        // TB plays the IR register
    logic        stop;
    logic        conFlag;
    logic        gra, grb, grc, rIn, rOut, baOut, pcOut, incPc, pcIn, irIn, yIn;
    logic        cOut, zLowOut, zIn, mdrOut, mdrIn, marIn, memRead, memWrite, conIn, run;
    aluOpT       aluOp;

    // One mask per strobe, used to build expected words
    localparam logic [20:0] mGra      = 21'd1 << 0;
    localparam logic [20:0] mGrb      = 21'd1 << 1;
    localparam logic [20:0] mGrc      = 21'd1 << 2;
    localparam logic [20:0] mRIn      = 21'd1 << 3;
    localparam logic [20:0] mROut     = 21'd1 << 4;
    localparam logic [20:0] mBaOut    = 21'd1 << 5;
    localparam logic [20:0] mPcOut    = 21'd1 << 6;
    localparam logic [20:0] mIncPc    = 21'd1 << 7;
    localparam logic [20:0] mPcIn     = 21'd1 << 8;
    localparam logic [20:0] mIrIn     = 21'd1 << 9;
    localparam logic [20:0] mYIn      = 21'd1 << 10;
    localparam logic [20:0] mCOut     = 21'd1 << 11;
    localparam logic [20:0] mZLowOut  = 21'd1 << 12;
    localparam logic [20:0] mZIn      = 21'd1 << 13;
    localparam logic [20:0] mMdrOut   = 21'd1 << 14;
    localparam logic [20:0] mMdrIn    = 21'd1 << 15;
    localparam logic [20:0] mMarIn    = 21'd1 << 16;
    localparam logic [20:0] mMemRead  = 21'd1 << 17;
    localparam logic [20:0] mMemWrite = 21'd1 << 18;
    localparam logic [20:0] mConIn    = 21'd1 << 19;
    localparam logic [20:0] mRun      = 21'd1 << 20;

    logic [31:0] rngState;      // xorshift state
    phaseT       modelPhase;    // Cycle model
    logic [2:0]  modelStep;
    int          doneCount;     // Completed instructions
    int          cycleCount;
    logic        haltNext;      // Next fetched word is a halt

    controlUnit UUT (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // ==================================================
    // Random source and ISA model
    // ==================================================
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic instrClassT classOf(input logic [4:0] op);
        case (op)
            opLoad:                return classLoad;
            opLoadImm:             return classLoadImm;
            opStore:               return classStore;
            opAddi, opAndi, opOri: return classAluImm;
            opBranch:              return classBranch;
            opHalt:                return classHalt;
            default:               return (op >= 5'd3 && op <= 5'd11) ? classAluReg : classNop;
        endcase
    endfunction

    function automatic aluOpT aluOf(input logic [4:0] op);
        case (op)
            opAddi:  return aluAdd;
            opAndi:  return aluAnd;
            opOri:   return aluOr;
            default: return aluOpT'(op);    // Register ops carry the ALU code number
        endcase
    endfunction

    function automatic int execLength(input instrClassT cls);
        case (cls)
            classLoad, classStore: return 5;
            classBranch:           return 4;
            classNop, classHalt:   return 0;
            default:               return 3;
        endcase
    endfunction

    function automatic logic [31:0] drawInstruction();
        logic [31:0] r;
        r = nextRandom();
        // Redraw until opcode is a kept one, halt held back for the end
        while ((classOf(r[31:27]) == classNop && r[31:27] != opNop) || r[31:27] == opHalt) begin
            r = nextRandom();
        end
        return r;
    endfunction

    // Expected {aluOp, strobes} for one cycle
    function automatic logic [25:0] expectedControl(input phaseT ph, input logic [2:0] stp,
            input logic [4:0] op, input logic con);
        instrClassT  cls;
        logic [20:0] s;
        aluOpT       alu;
        cls = classOf(op);
        s   = '0;
        alu = aluNone;
        case (ph)
            phaseFetch0:  s = mPcOut | mMarIn | mIncPc | mZIn;
            phaseFetch1:  s = mZLowOut | mPcIn | mMemRead | mMdrIn;
            phaseFetch2:  s = mMdrOut | mIrIn;
            phaseExecute: begin
                case ({cls, stp})
                    {classLoad, 3'd0}:    s = mGrb | mBaOut | mROut | mYIn;
                    {classLoad, 3'd1}:    s = mCOut | mZIn;
                    {classLoad, 3'd2}:    s = mZLowOut | mMarIn;
                    {classLoad, 3'd3}:    s = mMemRead | mMdrIn;
                    {classLoad, 3'd4}:    s = mMdrOut | mGra | mRIn;
                    {classLoadImm, 3'd0}: s = mGrb | mBaOut | mROut | mYIn;
                    {classLoadImm, 3'd1}: s = mCOut | mZIn;
                    {classLoadImm, 3'd2}: s = mZLowOut | mGra | mRIn;
                    {classStore, 3'd0}:   s = mGrb | mBaOut | mROut | mYIn;
                    {classStore, 3'd1}:   s = mCOut | mZIn;
                    {classStore, 3'd2}:   s = mZLowOut | mMarIn;
                    {classStore, 3'd3}:   s = mGra | mROut | mMdrIn;
                    {classStore, 3'd4}:   s = mMemWrite;
                    {classAluReg, 3'd0}:  s = mGrb | mROut | mYIn;
                    {classAluReg, 3'd1}:  s = mGrc | mROut | mZIn;      // Rc operand
                    {classAluReg, 3'd2}:  s = mZLowOut | mGra | mRIn;
                    {classAluImm, 3'd0}:  s = mGrb | mROut | mYIn;
                    {classAluImm, 3'd1}:  s = mCOut | mZIn;             // Constant operand
                    {classAluImm, 3'd2}:  s = mZLowOut | mGra | mRIn;
                    {classBranch, 3'd0}:  s = mGra | mROut | mConIn;
                    {classBranch, 3'd1}:  s = mPcOut | mYIn;
                    {classBranch, 3'd2}:  s = mCOut | mZIn;
                    {classBranch, 3'd3}:  s = mZLowOut | (con ? mPcIn : 21'd0);
                    default:              s = '0;
                endcase
            end
            default: s = '0;                    // Idle, decode, halted
        endcase
        if (ph == phaseExecute && stp == 3'd1 && cls inside {classAluReg, classAluImm})
            alu = aluOf(op);
        else if (ph == phaseExecute && stp == 3'd1 && cls inside {classLoad, classLoadImm, classStore})
            alu = aluAdd;                       // Address sum
        else if (ph == phaseExecute && stp == 3'd2 && cls == classBranch)
            alu = aluAdd;                       // PC plus displacement
        if (ph != phaseIdle && ph != phaseHalted)
            s = s | mRun;
        return {alu, s};
    endfunction

    // ==================================================
    // Checking
    // ==================================================
    task automatic checkValue(input string name, input logic [4:0] actual,
            input logic [4:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h (cycle %0d)",
                     name, actual, expected, cycleCount);
            $display("Something failed");
            $fatal(1, "stopping after mismatch");
        end
    endtask

    task automatic checkOutputs(input logic [25:0] e);
        logic [20:0] s;
        s = e[20:0];
        checkValue("gra", {4'd0, gra}, {4'd0, |(s & mGra)});
        checkValue("grb", {4'd0, grb}, {4'd0, |(s & mGrb)});
        checkValue("grc", {4'd0, grc}, {4'd0, |(s & mGrc)});
        checkValue("rIn", {4'd0, rIn}, {4'd0, |(s & mRIn)});
        checkValue("rOut", {4'd0, rOut}, {4'd0, |(s & mROut)});
        checkValue("baOut", {4'd0, baOut}, {4'd0, |(s & mBaOut)});
        checkValue("pcOut", {4'd0, pcOut}, {4'd0, |(s & mPcOut)});
        checkValue("incPc", {4'd0, incPc}, {4'd0, |(s & mIncPc)});
        checkValue("pcIn", {4'd0, pcIn}, {4'd0, |(s & mPcIn)});
        checkValue("irIn", {4'd0, irIn}, {4'd0, |(s & mIrIn)});
        checkValue("yIn", {4'd0, yIn}, {4'd0, |(s & mYIn)});
        checkValue("cOut", {4'd0, cOut}, {4'd0, |(s & mCOut)});
        checkValue("zLowOut", {4'd0, zLowOut}, {4'd0, |(s & mZLowOut)});
        checkValue("zIn", {4'd0, zIn}, {4'd0, |(s & mZIn)});
        checkValue("mdrOut", {4'd0, mdrOut}, {4'd0, |(s & mMdrOut)});
        checkValue("mdrIn", {4'd0, mdrIn}, {4'd0, |(s & mMdrIn)});
        checkValue("marIn", {4'd0, marIn}, {4'd0, |(s & mMarIn)});
        checkValue("memRead", {4'd0, memRead}, {4'd0, |(s & mMemRead)});
        checkValue("memWrite", {4'd0, memWrite}, {4'd0, |(s & mMemWrite)});
        checkValue("conIn", {4'd0, conIn}, {4'd0, |(s & mConIn)});
        checkValue("run", {4'd0, run}, {4'd0, |(s & mRun)});
        checkValue("aluOp", aluOp, e[25:21]);
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Something failed");
        $fatal(1, "stopping after timeout");
    endtask

    // One clock: drive at falling edge, check, then step the model
    task automatic runCycle(input logic stopLevel, input logic resetLevel);
        logic [31:0] r;
        instrClassT  cls;
        @(negedge clock);
        r       = nextRandom();
        reset   = resetLevel;
        stop    = stopLevel;
        conFlag = r[0];                         // Fresh condition every cycle
        if (resetLevel) begin
            modelPhase = phaseIdle;             // Async reset acts at once
            modelStep  = '0;
        end else if (modelPhase == phaseDecode) begin
            ir = haltNext ? {opHalt, r[26:0]} : drawInstruction();  // IR loaded last edge
        end
        #10;
        cycleCount++;
        checkOutputs(expectedControl(modelPhase, modelStep, ir[31:27], conFlag));
        cls = classOf(ir[31:27]);
        if (resetLevel) begin
            modelPhase = phaseIdle;
        end else if (stopLevel) begin
            modelPhase = phaseHalted;           // Stop beats everything
            modelStep  = '0;
        end else begin
            case (modelPhase)
                phaseIdle:   modelPhase = phaseFetch0;
                phaseFetch0: modelPhase = phaseFetch1;
                phaseFetch1: modelPhase = phaseFetch2;
                phaseFetch2: modelPhase = phaseDecode;
                phaseDecode: begin
                    modelStep = '0;
                    if (cls == classHalt) begin
                        modelPhase = phaseHalted;
                    end else if (cls == classNop) begin
                        modelPhase = phaseFetch0;   // Zero execute steps
                        doneCount++;
                    end else begin
                        modelPhase = phaseExecute;
                    end
                end
                phaseExecute: begin
                    if (int'(modelStep) == execLength(cls) - 1) begin
                        modelPhase = phaseFetch0;
                        modelStep  = '0;
                        doneCount++;
                    end else begin
                        modelStep = modelStep + 3'd1;
                    end
                end
                default: modelPhase = modelPhase;   // Halted stays
            endcase
        end
    endtask

    // ==================================================
    // Run control
    // ==================================================
    initial begin
        int waitCycles;
        rngState   = 32'd31791;
        reset      = 1'b1;
        stop       = 1'b0;
        conFlag    = 1'b0;
        ir         = '0;
        modelPhase = phaseIdle;
        modelStep  = '0;
        doneCount  = 0;
        cycleCount = 0;
        haltNext   = 1'b0;

        runCycle(1'b0, 1'b1);           // Reset high since time 0, two rising edges
        waitCycles = 0;
        while (doneCount < 300) begin   // 300 random instructions
            runCycle(1'b0, 1'b0);
            waitCycles++;
            if (waitCycles > 3000)
                reportTimeout("300 instructions to complete");
        end

        haltNext   = 1'b1;              // Halt opcode ends first run
        waitCycles = 0;
        while (modelPhase != phaseHalted) begin
            runCycle(1'b0, 1'b0);
            waitCycles++;
            if (waitCycles > 20)
                reportTimeout("the halt instruction to take effect");
        end
        repeat (20) runCycle(1'b0, 1'b0);

        // Second run, stop in the middle of an instruction
        haltNext = 1'b0;
        repeat (2) runCycle(1'b0, 1'b1);
        waitCycles = 0;
        while (!(modelPhase == phaseExecute && modelStep == 3'd1)) begin
            runCycle(1'b0, 1'b0);
            waitCycles++;
            if (waitCycles > 50)
                reportTimeout("an instruction to reach its second execute step");
        end
        runCycle(1'b1, 1'b0);           // Stop seen at next rising edge
        repeat (20) runCycle(1'b0, 1'b0);

        $display("Everything OK");
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/isaPkg.sv
common/sequencePkg.sv
decode/instrDecoder.sv
sequencer/stepSequencer.sv
signals/controlSignalGen.sv
hw/controlUnit.sv
tests/controlUnitTb.sv

/* run.sh */
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -f src.f --top-module controlUnitTb -o controlUnitTb

# Exit status of the simulation is the test result
./obj_dir/controlUnitTb
